// ==== list.f ====
+incdir+source
source/xosvm_pkg.sv
source/xosvm_if.sv
source/mvm_csr_bank.sv
source/mmu_lane.sv
source/mem_request_gate.sv
source/xosvm_unit.sv
test/xosvm_unit_checker.sv
test/xosvm_unit_tb.sv

// ==== source/mem_request_gate.sv ====
// Request strobe delay, memory operation enable and per-lane fault masking

`timescale 1ns/1ps
`default_nettype none

`include "xosvm_macros.svh"

module mem_request_gate
    import xosvm_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n_i,

    // Request strobes, sampled with the lane addresses
    input  logic                fetch_req_i,
    input  logic                mem_read_enable_i,
    input  byte_en_t            mem_write_enable_i,
    input  logic                killed_i,

    // Registered lane faults, indexed by lane_e
    input  logic [`N_LANES-1:0] fault_i,

    output logic                mem_operation_enable_o,
    output byte_en_t            mem_write_enable_o,
    output logic                inst_fault_o,
    output logic                data_fault_o
);

//////////////////////////////////////////////////////////////////////////////
// Strobe delay, in step with the lanes
//////////////////////////////////////////////////////////////////////////////

    logic     fetch_req_q;
    logic     read_q;
    byte_en_t write_q;
    logic     killed_q;

    // Data request of the delayed access
    logic     data_req;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_req_q <= 1'b0;
            read_q      <= 1'b0;
            write_q     <= '0;
            killed_q    <= 1'b0;
        end
        else begin
            fetch_req_q <= fetch_req_i;
            read_q      <= mem_read_enable_i;
            write_q     <= mem_write_enable_i;
            killed_q    <= killed_i;
        end
    end

//////////////////////////////////////////////////////////////////////////////
// Output forming, no added latency
//////////////////////////////////////////////////////////////////////////////

    // Any byte enable counts as a write
    assign data_req = read_q || (write_q != '0);

    // Killed or faulting accesses never reach memory
    assign mem_operation_enable_o = data_req && !killed_q && !fault_i[LANE_DATA];

    assign mem_write_enable_o = write_q;

    // A lane fault only matters when its lane carried a request
    assign inst_fault_o = fault_i[LANE_INST] && fetch_req_q;
    assign data_fault_o = fault_i[LANE_DATA] && data_req;

endmodule

`default_nettype wire

// ==== source/mmu_lane.sv ====
// Registered bounds check and mask-and-offset relocation of one address stream

`timescale 1ns/1ps
`default_nettype none

`include "xosvm_macros.svh"

module mmu_lane
    import xosvm_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,

    // Untranslated address, one per cycle
    input  word_t   address_i,

    // Segment configuration from the CSR bank
    mmu_cfg_if.lane cfg_i,

    // Translated address and fault, one cycle later
    output word_t   address_o,
    output logic    fault_o
);

    word_t address_next;
    logic  fault_next;

    always_comb begin
        if (cfg_i.en) begin
            // Unsigned compare, size is the first illegal address
            fault_next   = (address_i >= cfg_i.size);
            // Wraps modulo 2^XLEN
            address_next = (address_i & cfg_i.mask) + cfg_i.offset;
        end
        else begin
            // Bypass when translation is off
            fault_next   = 1'b0;
            address_next = address_i;
        end
    end

    // Single pipeline stage, no hold
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            address_o <= '0;
            fault_o   <= 1'b0;
        end
        else begin
            address_o <= address_next;
            fault_o   <= fault_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/mvm_csr_bank.sv ====
// XOSVM CSR registers, CSR read mux, translation enable and lane configuration

`timescale 1ns/1ps
`default_nettype none

`include "xosvm_macros.svh"

module mvm_csr_bank
    import xosvm_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    // Current hart privilege
    input  priv_e     privilege_i,

    // CSR access port
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  word_t     csr_wdata_i,
    output word_t     csr_rdata_o,

    // One configuration set per lane
    mmu_cfg_if.csr    cfg_o [`N_LANES]
);

//////////////////////////////////////////////////////////////////////////////
// Registers
//////////////////////////////////////////////////////////////////////////////

    // Only the enable bit of MVMCTL is implemented
    logic  mvmctl;

    // Data segment
    word_t mvmdo;
    word_t mvmds;
    word_t mvmdm;

    // Instruction segment
    word_t mvmio;
    word_t mvmis;
    word_t mvmim;

    logic  translate_en;

    // Write takes effect on the clock edge that samples csr_we_i
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mvmctl <= 1'b0;
            mvmdo  <= '0;
            mvmds  <= '0;
            mvmdm  <= '0;
            mvmio  <= '0;
            mvmis  <= '0;
            mvmim  <= '0;
        end
        else if (csr_we_i) begin
            case (csr_addr_i)
                `CSR_MVMCTL: mvmctl <= csr_wdata_i[0];
                `CSR_MVMDO:  mvmdo  <= csr_wdata_i;
                `CSR_MVMDS:  mvmds  <= csr_wdata_i;
                `CSR_MVMDM:  mvmdm  <= csr_wdata_i;
                `CSR_MVMIO:  mvmio  <= csr_wdata_i;
                `CSR_MVMIS:  mvmis  <= csr_wdata_i;
                `CSR_MVMIM:  mvmim  <= csr_wdata_i;
                // Addresses outside the XOSVM map are ignored
                default: ;
            endcase
        end
    end

//////////////////////////////////////////////////////////////////////////////
// Read mux
//////////////////////////////////////////////////////////////////////////////

    // Combinational read, unmapped addresses return zero
    always_comb begin
        case (csr_addr_i)
            `CSR_MVMCTL: csr_rdata_o = {{(`XLEN-1){1'b0}}, mvmctl};
            `CSR_MVMDO:  csr_rdata_o = mvmdo;
            `CSR_MVMDS:  csr_rdata_o = mvmds;
            `CSR_MVMDM:  csr_rdata_o = mvmdm;
            `CSR_MVMIO:  csr_rdata_o = mvmio;
            `CSR_MVMIS:  csr_rdata_o = mvmis;
            `CSR_MVMIM:  csr_rdata_o = mvmim;
            default:     csr_rdata_o = '0;
        endcase
    end

//////////////////////////////////////////////////////////////////////////////
// Enable rule and lane routing
//////////////////////////////////////////////////////////////////////////////

    // Machine mode always sees physical addresses
    assign translate_en = (privilege_i != PRIV_MACHINE) && mvmctl;

    // Fetch lane
    assign cfg_o[LANE_INST].en     = translate_en;
    assign cfg_o[LANE_INST].mask   = mvmim;
    assign cfg_o[LANE_INST].offset = mvmio;
    assign cfg_o[LANE_INST].size   = mvmis;

    // Data lane
    assign cfg_o[LANE_DATA].en     = translate_en;
    assign cfg_o[LANE_DATA].mask   = mvmdm;
    assign cfg_o[LANE_DATA].offset = mvmdo;
    assign cfg_o[LANE_DATA].size   = mvmds;

endmodule

`default_nettype wire

// ==== source/xosvm_if.sv ====
// Per-lane translation configuration interface with CSR and lane modports

`timescale 1ns/1ps
`default_nettype none

interface mmu_cfg_if
    import xosvm_pkg::*;
();

    // Translation active for this lane
    logic  en;
    // Address bits kept before relocation
    word_t mask;
    // Base added after masking
    word_t offset;
    // First raw address outside the segment
    word_t size;

    // Register bank side, drives the whole set
    modport csr (
        output en,
        output mask,
        output offset,
        output size
    );

    // Lane side, read only
    modport lane (
        input  en,
        input  mask,
        input  offset,
        input  size
    );

endinterface

`default_nettype wire

// ==== source/xosvm_macros.svh ====
// XOSVM CSR addresses, datapath widths and lane count

`ifndef XOSVM_MACROS_SVH
`define XOSVM_MACROS_SVH

//////////////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////////////

// Address and data width of the RV32 core
`define XLEN        32
// Standard CSR address field
`define CSR_ADDR_W  12
// One enable per byte of a word
`define BYTE_EN_W   4
// Instruction fetch lane and data access lane
`define N_LANES     2

//////////////////////////////////////////////////////////////////////////////
// XOSVM CSR map, custom machine read/write range
//////////////////////////////////////////////////////////////////////////////

// Control, only bit 0 is kept
`define CSR_MVMCTL  12'h7C0
// Data segment offset, size and mask
`define CSR_MVMDO   12'h7C1
`define CSR_MVMDS   12'h7C2
`define CSR_MVMDM   12'h7C3
// Instruction segment offset, size and mask
`define CSR_MVMIO   12'h7C4
`define CSR_MVMIS   12'h7C5
`define CSR_MVMIM   12'h7C6

`endif

// ==== source/xosvm_pkg.sv ====
// Shared vector types, privilege enum and lane index enum of the XOSVM unit

`default_nettype none

`include "xosvm_macros.svh"

package xosvm_pkg;

    // Address or register value
    typedef logic [`XLEN-1:0]       word_t;

    // CSR address as carried by the CSR port
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Write byte enables, one per byte lane of the bus
    typedef logic [`BYTE_EN_W-1:0]  byte_en_t;

    // RISC-V privilege levels
    // Encoding 2 is reserved and has no member
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    // Index into the per-lane arrays
    // Fetch lane first, data lane second
    typedef enum logic [0:0] {
        LANE_INST = 1'b0,
        LANE_DATA = 1'b1
    } lane_e;

endpackage

`default_nettype wire

// ==== source/xosvm_unit.sv ====
// XOSVM unit top level with CSR bank, translation lanes and request gate

`timescale 1ns/1ps
`default_nettype none

`include "xosvm_macros.svh"

module xosvm_unit
    import xosvm_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    // Privilege and CSR port
    input  priv_e     privilege_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  word_t     csr_wdata_i,
    output word_t     csr_rdata_o,

    // Instruction fetch side
    input  logic      fetch_req_i,
    input  word_t     fetch_address_i,
    output word_t     instruction_address_o,
    output logic      inst_fault_o,

    // Data access side
    input  logic      mem_read_enable_i,
    input  byte_en_t  mem_write_enable_i,
    input  word_t     mem_address_i,
    input  logic      killed_i,
    output word_t     mem_address_o,
    output byte_en_t  mem_write_enable_o,
    output logic      mem_operation_enable_o,
    output logic      data_fault_o
);

//////////////////////////////////////////////////////////////////////////////
// Lane arrays
//////////////////////////////////////////////////////////////////////////////

    mmu_cfg_if           cfg_if [`N_LANES] ();

    word_t               raw_address  [`N_LANES];
    word_t               xlat_address [`N_LANES];
    logic [`N_LANES-1:0] lane_fault;

    // Plain ports onto lane slots
    assign raw_address[LANE_INST] = fetch_address_i;
    assign raw_address[LANE_DATA] = mem_address_i;

    assign instruction_address_o  = xlat_address[LANE_INST];
    assign mem_address_o          = xlat_address[LANE_DATA];

//////////////////////////////////////////////////////////////////////////////
// CSR bank
//////////////////////////////////////////////////////////////////////////////

    mvm_csr_bank mvm_csr_bank_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .privilege_i (privilege_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .cfg_o       (cfg_if)
    );

    // One translation lane per address stream
    for (genvar i = 0; i < `N_LANES; i++) begin : gen_lane
        localparam lane_e LANE = lane_e'(i);

        mmu_lane mmu_lane_inst (
            .clk       (clk),
            .arst_n_i  (arst_n_i),
            .address_i (raw_address[LANE]),
            .cfg_i     (cfg_if[i]),
            .address_o (xlat_address[LANE]),
            .fault_o   (lane_fault[LANE])
        );
    end

//////////////////////////////////////////////////////////////////////////////
// Request gate
//////////////////////////////////////////////////////////////////////////////

    mem_request_gate mem_request_gate_inst (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .fetch_req_i            (fetch_req_i),
        .mem_read_enable_i      (mem_read_enable_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .killed_i               (killed_i),
        .fault_i                (lane_fault),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .inst_fault_o           (inst_fault_o),
        .data_fault_o           (data_fault_o)
    );

endmodule

`default_nettype wire

// ==== test/xosvm_unit_checker.sv ====
// Concurrent assertions on the XOSVM unit top-level ports and their bind to xosvm_unit

`timescale 1ns/1ps
`default_nettype none

module xosvm_unit_checker
    import xosvm_pkg::*;
(
    input logic     clk,
    input logic     arst_n_i,
    input logic     killed_i,
    input logic     mem_operation_enable_o,
    input byte_en_t mem_write_enable_o,
    input logic     inst_fault_o,
    input logic     data_fault_o
);

    // Failed assertions so far
    int unsigned n_failures = 0;

    // A faulting access never reaches memory
    enable_excludes_fault: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(mem_operation_enable_o && data_fault_o)
    ) else begin
        $error("memory enable raised together with data fault");
        n_failures++;
    end

    // Reset holds every control output low
    reset_quiet: assert property (
        @(posedge clk)
        !arst_n_i |-> (!mem_operation_enable_o && (mem_write_enable_o == '0) &&
                       !inst_fault_o && !data_fault_o)
    ) else begin
        $error("control output active during reset");
        n_failures++;
    end

    // Kill is sampled with the request one cycle ahead of the enable
    enable_needs_live_request: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_operation_enable_o |-> $past(!killed_i)
    ) else begin
        $error("memory enable for a killed request");
        n_failures++;
    end

endmodule

bind xosvm_unit xosvm_unit_checker xosvm_unit_checker_inst (
    .clk                    (clk),
    .arst_n_i               (arst_n_i),
    .killed_i               (killed_i),
    .mem_operation_enable_o (mem_operation_enable_o),
    .mem_write_enable_o     (mem_write_enable_o),
    .inst_fault_o           (inst_fault_o),
    .data_fault_o           (data_fault_o)
);

`default_nettype wire

// ==== test/xosvm_unit_tb.sv ====
// XOSVM unit testbench with clock, reset, stimulus table, reference model, checks and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "xosvm_macros.svh"

module xosvm_unit_tb
    import xosvm_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int N_ROWS          = 128;
    // Whole table plus reset plus slack
    localparam int WATCHDOG_CYCLES = N_ROWS + RESET_CYCLES + 16;

    // One table row with stimulus first and expected outputs last
    typedef struct packed {
        logic [1:0]  priv;
        logic        csr_we;
        logic [11:0] csr_addr;
        logic [31:0] csr_wdata;
        logic        fetch_req;
        logic [31:0] fetch_addr;
        logic        rd;
        logic [3:0]  wen;
        logic [31:0] mem_addr;
        logic        kill;
        logic [31:0] exp_iaddr;
        logic        exp_ifault;
        logic [31:0] exp_maddr;
        logic [3:0]  exp_wen;
        logic        exp_op;
        logic        exp_dfault;
        logic [31:0] exp_rdata;
    } row_t;

    logic      clk;
    logic      arst_n_i;
    priv_e     privilege_i;
    logic      csr_we_i;
    csr_addr_t csr_addr_i;
    word_t     csr_wdata_i;
    word_t     csr_rdata_o;
    logic      fetch_req_i;
    word_t     fetch_address_i;
    word_t     instruction_address_o;
    logic      inst_fault_o;
    logic      mem_read_enable_i;
    byte_en_t  mem_write_enable_i;
    word_t     mem_address_i;
    logic      killed_i;
    word_t     mem_address_o;
    byte_en_t  mem_write_enable_o;
    logic      mem_operation_enable_o;
    logic      data_fault_o;

    row_t   rows [N_ROWS];
    int     n_rows;
    integer seed;

    // Assertion failures in the bound checker
    int unsigned assert_failures;

    // Reference copy of the XOSVM registers
    logic   m_ctl;
    word_t  m_do;
    word_t  m_ds;
    word_t  m_dm;
    word_t  m_io;
    word_t  m_is;
    word_t  m_im;

    xosvm_unit xosvm_unit_inst (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .privilege_i            (privilege_i),
        .csr_we_i               (csr_we_i),
        .csr_addr_i             (csr_addr_i),
        .csr_wdata_i            (csr_wdata_i),
        .csr_rdata_o            (csr_rdata_o),
        .fetch_req_i            (fetch_req_i),
        .fetch_address_i        (fetch_address_i),
        .instruction_address_o  (instruction_address_o),
        .inst_fault_o           (inst_fault_o),
        .mem_read_enable_i      (mem_read_enable_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .mem_address_i          (mem_address_i),
        .killed_i               (killed_i),
        .mem_address_o          (mem_address_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .data_fault_o           (data_fault_o)
    );

    assign assert_failures = xosvm_unit_inst.xosvm_unit_checker_inst.n_failures;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation timed out before every table row was checked");
        $display("test failed");
        $fatal(1);
    end

    always @(negedge clk) begin
        if (assert_failures != 0) begin
            $display("Concurrent assertion in the bound checker failed");
            $display("test failed");
            $fatal(1);
        end
    end

//////////////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////////////

    // Mask then offset with wrap at 32 bits
    function automatic word_t relocate(input word_t addr, input word_t mask,
                                       input word_t offset, input logic en);
        return en ? ((addr & mask) + offset) : addr;
    endfunction

    // Size is the first address outside the segment
    function automatic logic out_of_segment(input word_t addr, input word_t size, input logic en);
        return en && (addr >= size);
    endfunction

    function automatic word_t csr_read(input csr_addr_t addr);
        case (addr)
            `CSR_MVMCTL: return {31'd0, m_ctl};
            `CSR_MVMDO:  return m_do;
            `CSR_MVMDS:  return m_ds;
            `CSR_MVMDM:  return m_dm;
            `CSR_MVMIO:  return m_io;
            `CSR_MVMIS:  return m_is;
            `CSR_MVMIM:  return m_im;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic csr_write(input csr_addr_t addr, input word_t data);
        case (addr)
            `CSR_MVMCTL: m_ctl = data[0];
            `CSR_MVMDO:  m_do  = data;
            `CSR_MVMDS:  m_ds  = data;
            `CSR_MVMDM:  m_dm  = data;
            `CSR_MVMIO:  m_io  = data;
            `CSR_MVMIS:  m_is  = data;
            `CSR_MVMIM:  m_im  = data;
            default: ;
        endcase
    endtask

    // Walks the table in order with registers as seen before each row's write
    task automatic fill_expected();
        row_t r;
        logic en;
        logic inst_out;
        logic data_out;
        logic data_req;
        m_ctl = 1'b0;
        m_do  = '0;
        m_ds  = '0;
        m_dm  = '0;
        m_io  = '0;
        m_is  = '0;
        m_im  = '0;
        for (int i = 0; i < n_rows; i++) begin
            r            = rows[i];
            en           = (r.priv != 2'd3) && m_ctl;
            inst_out     = out_of_segment(r.fetch_addr, m_is, en);
            data_out     = out_of_segment(r.mem_addr, m_ds, en);
            data_req     = r.rd || (r.wen != 4'd0);
            r.exp_iaddr  = relocate(r.fetch_addr, m_im, m_io, en);
            r.exp_maddr  = relocate(r.mem_addr, m_dm, m_do, en);
            r.exp_ifault = inst_out && r.fetch_req;
            r.exp_dfault = data_out && data_req;
            r.exp_op     = data_req && !r.kill && !data_out;
            r.exp_wen    = r.wen;
            // Read data is sampled after the write edge
            if (r.csr_we)
                csr_write(r.csr_addr, r.csr_wdata);
            r.exp_rdata  = csr_read(r.csr_addr);
            rows[i]      = r;
        end
    endtask

//////////////////////////////////////////////////////////////////////////////
// Stimulus table
//////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input priv_e priv, input logic we, input csr_addr_t caddr,
                           input word_t wdata, input logic freq, input word_t faddr,
                           input logic rd, input byte_en_t wen, input word_t maddr,
                           input logic kill);
        row_t r;
        r            = '0;
        r.priv       = priv;
        r.csr_we     = we;
        r.csr_addr   = caddr;
        r.csr_wdata  = wdata;
        r.fetch_req  = freq;
        r.fetch_addr = faddr;
        r.rd         = rd;
        r.wen        = wen;
        r.mem_addr   = maddr;
        r.kill       = kill;
        rows[n_rows] = r;
        n_rows++;
    endtask

    // Random addresses on both lanes with the CSR port idle
    task automatic random_access(input priv_e priv, input logic rd, input byte_en_t wen,
                                 input logic kill);
        add_row(priv, 1'b0, `CSR_MVMCTL, 32'd0, 1'b1, $random(seed),
                rd, wen, $random(seed), kill);
    endtask

    // CSR write with a random read request riding along
    task automatic csr_access(input priv_e priv, input csr_addr_t addr, input word_t data);
        add_row(priv, 1'b1, addr, data, 1'b1, $random(seed), 1'b1, 4'd0, $random(seed), 1'b0);
    endtask

    task automatic build_table();
        csr_addr_t reset_reads [8];
        reset_reads = '{`CSR_MVMCTL, `CSR_MVMDO, `CSR_MVMDS, `CSR_MVMDM,
                        `CSR_MVMIO, `CSR_MVMIS, `CSR_MVMIM, 12'h7C7};
        // Every register reads zero out of reset
        foreach (reset_reads[k])
            add_row(PRIV_MACHINE, 1'b0, reset_reads[k], 32'd0, 1'b0, 32'd0,
                    1'b0, 4'd0, 32'd0, 1'b0);
        // Readback where MVMCTL keeps bit 0 and the unmapped write is lost
        csr_access(PRIV_MACHINE, `CSR_MVMCTL, 32'hFFFF_FFFF);
        csr_access(PRIV_MACHINE, `CSR_MVMIM,  32'h0000_FFFF);
        csr_access(PRIV_MACHINE, `CSR_MVMIO,  32'h4000_0000);
        csr_access(PRIV_MACHINE, `CSR_MVMIS,  32'h8000_0000);
        csr_access(PRIV_MACHINE, `CSR_MVMDM,  32'h000F_FFFC);
        csr_access(PRIV_MACHINE, `CSR_MVMDO,  32'hC000_0000);
        csr_access(PRIV_MACHINE, `CSR_MVMDS,  32'h6000_0000);
        csr_access(PRIV_MACHINE, 12'h7C7,     32'hDEAD_BEEF);
        // Machine mode bypasses translation
        repeat (6)
            random_access(PRIV_MACHINE, 1'b1, $random(seed), 1'b0);
        // User mode with MVMCTL cleared also bypasses
        csr_access(PRIV_USER, `CSR_MVMCTL, 32'd0);
        repeat (6)
            random_access(PRIV_USER, 1'b1, $random(seed), 1'b0);
        // Back-to-back accesses with translation on
        csr_access(PRIV_USER, `CSR_MVMCTL, 32'd1);
        repeat (24)
            random_access(PRIV_USER, $random(seed), $random(seed), 1'b0);
        repeat (4)
            random_access(PRIV_SUPERVISOR, 1'b1, 4'd0, 1'b0);
        // Every byte enable pattern with killed and idle cycles
        for (int be = 0; be < 16; be++) begin
            random_access(PRIV_USER, 1'b0, be[3:0], 1'b0);
            random_access(PRIV_USER, be[0], be[3:0], be[3]);
        end
        // Faulting read and in-segment read before an idle cycle out of range
        add_row(PRIV_USER, 1'b0, `CSR_MVMDS, 32'd0, 1'b1, 32'h0000_0100,
                1'b1, 4'd0, 32'hFFFF_FFF0, 1'b0);
        add_row(PRIV_USER, 1'b0, `CSR_MVMIS, 32'd0, 1'b1, 32'h0000_0200,
                1'b1, 4'd0, 32'h0000_1000, 1'b0);
        add_row(PRIV_USER, 1'b0, `CSR_MVMIM, 32'd0, 1'b0, 32'hFFFF_FFFF,
                1'b0, 4'd0, 32'hFFFF_FFFF, 1'b0);
        // Both lanes exactly at their size and then one below it
        add_row(PRIV_USER, 1'b0, `CSR_MVMCTL, 32'd0, 1'b1, 32'h8000_0000,
                1'b1, 4'd0, 32'h6000_0000, 1'b0);
        add_row(PRIV_USER, 1'b0, `CSR_MVMCTL, 32'd0, 1'b1, 32'h7FFF_FFFF,
                1'b0, 4'hF, 32'h5FFF_FFFF, 1'b0);
    endtask

//////////////////////////////////////////////////////////////////////////////
// Drive and check
//////////////////////////////////////////////////////////////////////////////

    task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                           input int idx, input string what);
        if (got !== expected) begin
            $display("ERR %0t: row %0d %s is %h, expected %h", $time, idx, what, got, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input row_t r);
        privilege_i        = priv_e'(r.priv);
        csr_we_i           = r.csr_we;
        csr_addr_i         = r.csr_addr;
        csr_wdata_i        = r.csr_wdata;
        fetch_req_i        = r.fetch_req;
        fetch_address_i    = r.fetch_addr;
        mem_read_enable_i  = r.rd;
        mem_write_enable_i = r.wen;
        mem_address_i      = r.mem_addr;
        killed_i           = r.kill;
    endtask

    task automatic check_row(input int idx, input row_t r);
        compare(instruction_address_o,  r.exp_iaddr,  idx, "instruction address");
        compare(inst_fault_o,           r.exp_ifault, idx, "inst fault");
        compare(mem_address_o,          r.exp_maddr,  idx, "mem address");
        compare(mem_write_enable_o,     r.exp_wen,    idx, "mem write enable");
        compare(mem_operation_enable_o, r.exp_op,     idx, "mem operation enable");
        compare(data_fault_o,           r.exp_dfault, idx, "data fault");
        compare(csr_rdata_o,            r.exp_rdata,  idx, "csr read data");
    endtask

    initial begin
        seed               = 32'hf53;
        n_rows             = 0;
        arst_n_i           = 1'b0;
        privilege_i        = PRIV_MACHINE;
        csr_we_i           = 1'b0;
        csr_addr_i         = '0;
        csr_wdata_i        = '0;
        fetch_req_i        = 1'b0;
        fetch_address_i    = '0;
        mem_read_enable_i  = 1'b0;
        mem_write_enable_i = '0;
        mem_address_i      = '0;
        killed_i           = 1'b0;
        build_table();
        fill_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        // Outputs still at their reset values
        compare(instruction_address_o,  32'd0, -1, "instruction address in reset");
        compare(mem_address_o,          32'd0, -1, "mem address in reset");
        compare(inst_fault_o,           32'd0, -1, "inst fault in reset");
        compare(data_fault_o,           32'd0, -1, "data fault in reset");
        compare(mem_operation_enable_o, 32'd0, -1, "mem operation enable in reset");
        compare(mem_write_enable_o,     32'd0, -1, "mem write enable in reset");
        arst_n_i = 1'b1;
        // Row i sampled on the next rising edge and checked on the next falling edge
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
            @(negedge clk);
            check_row(i, rows[i]);
        end
        if (assert_failures == 0) begin
            $display("test passed");
            $finish;
        end
        else begin
            $display("Concurrent assertion in the bound checker failed");
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
